// File: common/tcu_macros.svh
// Size constants of the dot-product lane, included by the interface and RTL blocks
`ifndef TCU_MACROS_SVH
`define TCU_MACROS_SVH

// Terms per request, four products plus C
`define TCU_TERMS 5

// Term sets held between producer and consumer
`define TCU_FIFO_DEPTH 4

// Signed accumulator width
`define TCU_ACC_BITS 32

`endif

// File: common/tcu_pkg.sv
// Shared types for the dot-product lane, imported by every RTL block
`default_nettype none

package tcu_pkg;

    // Operand format code, bit 3 set for integer formats
    typedef enum logic [3:0] {
        FMT_FP16 = 4'd1,
        FMT_BF16 = 4'd2,
        FMT_INT8 = 4'd9
    } tcu_fmt_e;

    // Biased exponent, bias 127
    typedef logic [7:0] tcu_exp_t;

    // Raw term: sign plus 24-bit magnitude, or a signed integer for INT8
    typedef logic [24:0] tcu_sig_t;

    // One 16-bit operand element
    typedef logic [15:0] tcu_elem_t;

    // C value or result word
    typedef logic [31:0] tcu_word_t;

endpackage : tcu_pkg

`default_nettype wire

// File: common/tcu_lane_if.sv
// One aligned set of terms passed between the producer, the FIFO and the consumer
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

interface tcu_lane_if;
    import tcu_pkg::*;

    logic                         valid;
    tcu_fmt_e                     fmt;
    tcu_exp_t                     max_exp;
    tcu_exp_t [`TCU_TERMS-1:0]    shift_amounts;
    tcu_sig_t [`TCU_TERMS-1:0]    raw_sigs;
    // Removes the head set, driven by the receiving side
    logic                         pop;

    modport source (
        output valid, fmt, max_exp, shift_amounts, raw_sigs,
        input  pop
    );

    modport sink (
        input  valid, fmt, max_exp, shift_amounts, raw_sigs,
        output pop
    );

endinterface : tcu_lane_if

`default_nettype wire

// File: mul_exp/tcu_half_mul.sv
// 16-bit floating multiplier for one lane, instantiated per format by the producer
`timescale 1ns/1ps
`default_nettype none

module tcu_half_mul #(
    parameter int EXP_BITS = 5
) (
    input  wire  tcu_pkg::tcu_elem_t a,
    input  wire  tcu_pkg::tcu_elem_t b,
    output logic                     sign_y,
    output tcu_pkg::tcu_exp_t        raw_exp_y,
    output logic [23:0]              raw_sig_y
);

    localparam int FRAC_BITS = 15 - EXP_BITS;
    localparam int SIG_BITS  = FRAC_BITS + 1;
    localparam int PROD_BITS = 2 * SIG_BITS;
    localparam int BIAS      = (1 << (EXP_BITS - 1)) - 1;
    // Moves the product's top bit up to bit 23
    localparam int ALIGN     = 24 - PROD_BITS;

    logic [EXP_BITS-1:0]  exp_a;
    logic [EXP_BITS-1:0]  exp_b;
    logic [SIG_BITS-1:0]  sig_a;
    logic [SIG_BITS-1:0]  sig_b;
    logic [PROD_BITS-1:0] prod;
    logic [9:0]           exp_sum;
    logic                 is_zero;

    assign exp_a = a[14 -: EXP_BITS];
    assign exp_b = b[14 -: EXP_BITS];

    // Hidden one restored
    assign sig_a = {1'b1, a[FRAC_BITS-1:0]};
    assign sig_b = {1'b1, b[FRAC_BITS-1:0]};

    // Zero exponent field flushes the operand to zero
    assign is_zero = (exp_a == '0) || (exp_b == '0);

    assign prod = sig_a * sig_b;

    // Rebias to 127, one extra since bit 23 carries the product's 2^1 weight
    assign exp_sum = 10'(exp_a) + 10'(exp_b) - 10'(2 * BIAS) + 10'd128;

    assign sign_y    = a[15] ^ b[15];
    assign raw_exp_y = is_zero ? 8'd0 : exp_sum[7:0];
    assign raw_sig_y = is_zero ? 24'd0 : (24'(prod) << ALIGN);

endmodule : tcu_half_mul

`default_nettype wire

// File: mul_exp/tcu_max_exp.sv
// Largest term exponent and per-term alignment distances, used by the producer
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_max_exp (
    input  wire  tcu_pkg::tcu_exp_t [`TCU_TERMS-1:0] exponents,
    output tcu_pkg::tcu_exp_t                        max_exp,
    output tcu_pkg::tcu_exp_t [`TCU_TERMS-1:0]       shift_amounts
);

    // Running maximum over all terms
    always_comb begin
        max_exp = exponents[0];
        for (int i = 1; i < `TCU_TERMS; i++) begin
            if (exponents[i] > max_exp) begin
                max_exp = exponents[i];
            end
        end
    end

    // Never negative since max_exp is the largest
    for (genvar i = 0; i < `TCU_TERMS; i++) begin : g_shift
        assign shift_amounts[i] = max_exp - exponents[i];
    end

endmodule : tcu_max_exp

`default_nettype wire

// File: mul_exp/tcu_mul_exp.sv
// Producer stage: per-format lane products, C term, exponent alignment, registered set
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_mul_exp (
    input  wire clk,
    input  wire reset,
    input  wire in_valid,
    input  wire tcu_pkg::tcu_fmt_e                    fmt,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0]  a_rows,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0]  b_cols,
    input  wire tcu_pkg::tcu_word_t                   c_val,
    tcu_lane_if.source                                out
);
    import tcu_pkg::*;

    logic [`TCU_TERMS-2:0]        sign_fp16;
    tcu_exp_t [`TCU_TERMS-2:0]    exp_fp16;
    logic [`TCU_TERMS-2:0][23:0]  sig_fp16;
    logic [`TCU_TERMS-2:0]        sign_bf16;
    tcu_exp_t [`TCU_TERMS-2:0]    exp_bf16;
    logic [`TCU_TERMS-2:0][23:0]  sig_bf16;
    logic [`TCU_TERMS-2:0][16:0]  prod_int8;
    tcu_exp_t [`TCU_TERMS-1:0]    term_exp;
    tcu_sig_t [`TCU_TERMS-1:0]    term_sig;
    tcu_exp_t                     max_exp;
    tcu_exp_t [`TCU_TERMS-1:0]    shift_amounts;
    logic                         c_nonzero;

    for (genvar i = 0; i < `TCU_TERMS - 1; i++) begin : g_lane
        logic signed [15:0] prod_hi;
        logic signed [15:0] prod_lo;

        tcu_half_mul #(.EXP_BITS(5)) fp16_mul (
            .a         (a_rows[i]),
            .b         (b_cols[i]),
            .sign_y    (sign_fp16[i]),
            .raw_exp_y (exp_fp16[i]),
            .raw_sig_y (sig_fp16[i])
        );

        tcu_half_mul #(.EXP_BITS(8)) bf16_mul (
            .a         (a_rows[i]),
            .b         (b_cols[i]),
            .sign_y    (sign_bf16[i]),
            .raw_exp_y (exp_bf16[i]),
            .raw_sig_y (sig_bf16[i])
        );

        // Two signed byte products summed into 17 bits
        assign prod_hi = $signed(a_rows[i][15:8]) * $signed(b_cols[i][15:8]);
        assign prod_lo = $signed(a_rows[i][7:0]) * $signed(b_cols[i][7:0]);
        assign prod_int8[i] = {prod_hi[15], prod_hi} + {prod_lo[15], prod_lo};

        always_comb begin
            case (fmt)
                FMT_FP16: begin
                    term_exp[i] = exp_fp16[i];
                    term_sig[i] = {sign_fp16[i], sig_fp16[i]};
                end
                FMT_BF16: begin
                    term_exp[i] = exp_bf16[i];
                    term_sig[i] = {sign_bf16[i], sig_bf16[i]};
                end
                FMT_INT8: begin
                    term_exp[i] = 8'd0;
                    term_sig[i] = {{8{prod_int8[i][16]}}, prod_int8[i]};
                end
                default: begin
                    term_exp[i] = 8'd0;
                    term_sig[i] = '0;
                end
            endcase
        end
    end

    // C is the last term, already FP32 so no rebias
    assign c_nonzero = (c_val[30:23] != 8'd0);
    assign term_exp[`TCU_TERMS-1] = fmt[3] ? 8'd0 : c_val[30:23];
    assign term_sig[`TCU_TERMS-1] = fmt[3] ? c_val[24:0]
                                  : {c_val[31], c_nonzero, c_nonzero ? c_val[22:0] : 23'd0};

    tcu_max_exp find_max (
        .exponents     (term_exp),
        .max_exp       (max_exp),
        .shift_amounts (shift_amounts)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out.fmt           <= fmt;
            out.max_exp       <= max_exp;
            out.shift_amounts <= shift_amounts;
            out.raw_sigs      <= term_sig;
        end
    end

endmodule : tcu_mul_exp

`default_nettype wire

// File: source/tcu_term_fifo.sv
// Circular buffer of aligned term sets between the producer and the consumer
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_term_fifo (
    input  wire        clk,
    input  wire        reset,
    tcu_lane_if.sink   wr,
    tcu_lane_if.source rd,
    output logic       full
);
    import tcu_pkg::*;

    localparam int PTR_BITS = $clog2(`TCU_FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`TCU_FIFO_DEPTH + 1);

    tcu_fmt_e                  fmt_mem     [`TCU_FIFO_DEPTH];
    tcu_exp_t                  max_exp_mem [`TCU_FIFO_DEPTH];
    tcu_exp_t [`TCU_TERMS-1:0] shift_mem   [`TCU_FIFO_DEPTH];
    tcu_sig_t [`TCU_TERMS-1:0] sig_mem     [`TCU_FIFO_DEPTH];
    logic [PTR_BITS-1:0]       wr_ptr;
    logic [PTR_BITS-1:0]       rd_ptr;
    logic [CNT_BITS-1:0]       count;
    logic                      do_write;
    logic                      do_read;

    // Write side never pops
    assign wr.pop = 1'b0;

    assign full     = (count == CNT_BITS'(`TCU_FIFO_DEPTH));
    assign do_write = wr.valid && !full;
    assign do_read  = rd.pop && (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous write and read keeps the count
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            fmt_mem[wr_ptr]     <= wr.fmt;
            max_exp_mem[wr_ptr] <= wr.max_exp;
            shift_mem[wr_ptr]   <= wr.shift_amounts;
            sig_mem[wr_ptr]     <= wr.raw_sigs;
        end
    end

    // Head entry shown while not empty
    assign rd.valid         = (count != '0);
    assign rd.fmt           = fmt_mem[rd_ptr];
    assign rd.max_exp       = max_exp_mem[rd_ptr];
    assign rd.shift_amounts = shift_mem[rd_ptr];
    assign rd.raw_sigs      = sig_mem[rd_ptr];

endmodule : tcu_term_fifo

`default_nettype wire

// File: accumulate/tcu_align_acc.sv
// Consumer: serial align-and-accumulate of one term set, then normalization to FP32
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_align_acc (
    input  wire                clk,
    input  wire                reset,
    tcu_lane_if.sink           in,
    output logic               result_valid,
    output tcu_pkg::tcu_word_t result
);
    import tcu_pkg::*;

    localparam int ACC      = `TCU_ACC_BITS;
    localparam int IDX_BITS = $clog2(`TCU_TERMS);
    localparam int POS_BITS = $clog2(`TCU_ACC_BITS);

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        NORM
    } state_e;

    state_e                    state;
    logic [IDX_BITS-1:0]       term_idx;
    tcu_fmt_e                  fmt_q;
    tcu_exp_t                  max_exp_q;
    tcu_exp_t [`TCU_TERMS-1:0] shift_q;
    tcu_sig_t [`TCU_TERMS-1:0] sig_q;
    logic signed [ACC-1:0]     acc;
    tcu_sig_t                  cur_sig;
    tcu_exp_t                  cur_shift;
    logic signed [ACC-1:0]     cur_mag;
    logic signed [ACC-1:0]     signed_term;
    logic signed [ACC-1:0]     term_val;
    logic [ACC-1:0]            mag;
    logic [POS_BITS-1:0]       lead_pos;
    logic [ACC-1:0]            mag_top;
    tcu_word_t                 norm_word;

    // Take the head set as soon as we are free
    assign in.pop = (state == IDLE) && in.valid;

    // Current term, signed and aligned to max_exp
    always_comb begin
        cur_sig     = sig_q[term_idx];
        cur_shift   = shift_q[term_idx];
        cur_mag     = $signed({{(ACC - 24){1'b0}}, cur_sig[23:0]});
        signed_term = cur_sig[24] ? -cur_mag : cur_mag;
        if (fmt_q[3]) begin
            term_val = {{(ACC - 25){cur_sig[24]}}, cur_sig};
        end else if (cur_shift >= ACC) begin
            // Shifted out completely
            term_val = '0;
        end else begin
            term_val = signed_term >>> cur_shift;
        end
    end

    // Leading one search and FP32 packing
    always_comb begin
        mag      = acc[ACC-1] ? -acc : acc;
        lead_pos = '0;
        for (int i = 0; i < ACC; i++) begin
            if (mag[i]) begin
                lead_pos = POS_BITS'(i);
            end
        end
        // Leading one moved to the top bit, mantissa follows below it
        mag_top = mag << (POS_BITS'(ACC - 1) - lead_pos);
        if (fmt_q[3]) begin
            norm_word = tcu_word_t'(acc);
        end else if (mag == '0) begin
            norm_word = '0;
        end else begin
            norm_word = {acc[ACC-1], max_exp_q + 8'(lead_pos) - 8'd23, mag_top[ACC-2 -: 23]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            term_idx     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (in.valid) begin
                        state    <= ACCUM;
                        term_idx <= '0;
                    end
                end
                ACCUM: begin
                    term_idx <= term_idx + 1'b1;
                    if (term_idx == IDX_BITS'(`TCU_TERMS - 1)) begin
                        state <= NORM;
                    end
                end
                NORM: begin
                    result_valid <= 1'b1;
                    state        <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in.pop) begin
            fmt_q     <= in.fmt;
            max_exp_q <= in.max_exp;
            shift_q   <= in.shift_amounts;
            sig_q     <= in.raw_sigs;
            acc       <= '0;
        end else if (state == ACCUM) begin
            acc <= acc + term_val;
        end
        // Held until the next set finishes
        if (state == NORM) begin
            result <= norm_word;
        end
    end

endmodule : tcu_align_acc

`default_nettype wire

// File: source/tcu_dot_top.sv
// Top level of the dot-product lane: producer, term FIFO and accumulator
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_dot_top (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      in_valid,
    input  wire tcu_pkg::tcu_fmt_e                   fmt,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0] a_rows,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0] b_cols,
    input  wire tcu_pkg::tcu_word_t                  c_val,
    output logic                                     busy,
    output logic                                     result_valid,
    output tcu_pkg::tcu_word_t                       result
);

    // Producer to FIFO, and FIFO head to consumer
    tcu_lane_if prod_if ();
    tcu_lane_if cons_if ();

    tcu_mul_exp mul_exp0 (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .fmt      (fmt),
        .a_rows   (a_rows),
        .b_cols   (b_cols),
        .c_val    (c_val),
        .out      (prod_if.source)
    );

    // Full FIFO is reported as busy
    tcu_term_fifo fifo0 (
        .clk   (clk),
        .reset (reset),
        .wr    (prod_if.sink),
        .rd    (cons_if.source),
        .full  (busy)
    );

    tcu_align_acc align_acc0 (
        .clk          (clk),
        .reset        (reset),
        .in           (cons_if.sink),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule : tcu_dot_top

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock of 20 ns and a synchronous reset held for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

// File: tests/tcu_checker.sv
// Reference model of the lane, queues expected results and compares them with the DUT
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_checker (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      in_valid,
    input  wire tcu_pkg::tcu_fmt_e                   fmt,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0] a_rows,
    input  wire tcu_pkg::tcu_elem_t [`TCU_TERMS-2:0] b_cols,
    input  wire tcu_pkg::tcu_word_t                  c_val,
    input  wire                                      busy,
    input  wire                                      result_valid,
    input  wire tcu_pkg::tcu_word_t                  result,
    output int                                       compare_count,
    output int                                       error_count
);
    import tcu_pkg::*;

    logic [31:0] expect_q[$];

    // Product of two floating elements, significand left-aligned to bit 23
    function automatic void fp_product(input logic [15:0] a, input logic [15:0] b,
                                       input int exp_bits, output bit sign,
                                       output int exp, output longint sig);
        int frac_bits;
        int bias;
        int ea;
        int eb;
        longint ma;
        longint mb;
        frac_bits = 15 - exp_bits;
        bias = (1 << (exp_bits - 1)) - 1;
        ea = (a >> frac_bits) & ((1 << exp_bits) - 1);
        eb = (b >> frac_bits) & ((1 << exp_bits) - 1);
        sign = a[15] ^ b[15];
        if (ea == 0 || eb == 0) begin
            exp = 0;
            sig = 0;
        end else begin
            ma = (1 << frac_bits) | (a & ((1 << frac_bits) - 1));
            mb = (1 << frac_bits) | (b & ((1 << frac_bits) - 1));
            sig = (ma * mb) << (24 - 2 * (frac_bits + 1));
            exp = (ea + eb - 2 * bias + 128) & 255;
        end
    endfunction

    function automatic logic [31:0] expected_result(input tcu_fmt_e f,
                                                    input logic [3:0][15:0] a,
                                                    input logic [3:0][15:0] b,
                                                    input logic [31:0] c);
        bit     sgn [5];
        int     ex  [5];
        longint sg  [5];
        int     maxe;
        int     p;
        int     e;
        longint acc;
        longint v;
        longint mag;
        longint mant;
        if (f == FMT_INT8) begin
            acc = longint'($signed(c[24:0]));
            for (int i = 0; i < 4; i++) begin
                acc += int'($signed(a[i][15:8])) * int'($signed(b[i][15:8]));
                acc += int'($signed(a[i][7:0])) * int'($signed(b[i][7:0]));
            end
            return acc[31:0];
        end
        for (int i = 0; i < 4; i++) begin
            fp_product(a[i], b[i], (f == FMT_FP16) ? 5 : 8, sgn[i], ex[i], sg[i]);
        end
        sgn[4] = c[31];
        ex[4] = c[30:23];
        sg[4] = (ex[4] != 0) ? ((longint'(1) << 23) | c[22:0]) : 0;
        maxe = 0;
        for (int i = 0; i < 5; i++) begin
            if (ex[i] > maxe) maxe = ex[i];
        end
        acc = 0;
        for (int i = 0; i < 5; i++) begin
            if (maxe - ex[i] < 32) begin
                v = sgn[i] ? -sg[i] : sg[i];
                acc += v >>> (maxe - ex[i]);
            end
        end
        if (acc == 0) return 32'h0;
        mag = (acc < 0) ? -acc : acc;
        p = 0;
        for (int i = 0; i < 40; i++) begin
            if ((mag >> i) & 1) p = i;
        end
        e = (maxe + p - 23) & 255;
        mant = (p >= 23) ? (mag >> (p - 23)) : (mag << (23 - p));
        return {acc < 0, e[7:0], mant[22:0]};
    endfunction

    initial begin
        compare_count = 0;
        error_count = 0;
    end

    always @(posedge clk) begin
        // Full FIFO means at least that many sets are still pending
        if (!reset && busy && expect_q.size() < `TCU_FIFO_DEPTH) begin
            $display("busy was high with only %0d requests pending", expect_q.size());
            error_count = error_count + 1;
        end
        if (!reset && in_valid) begin
            expect_q.push_back(expected_result(fmt, a_rows, b_cols, c_val));
        end
        if (!reset && result_valid) begin
            if (expect_q.size() == 0) begin
                $display("result_valid pulsed with no request pending");
                error_count = error_count + 1;
            end else begin
                if (result !== expect_q[0]) begin
                    $display("MISMATCH result: expected %08h, got %08h", expect_q[0], result);
                    error_count = error_count + 1;
                end
                void'(expect_q.pop_front());
                compare_count = compare_count + 1;
            end
        end
    end

endmodule : tcu_checker

`default_nettype wire

// File: tests/tcu_tb.sv
// Testbench top: seeds the generator, drives random and directed requests, prints the summary
`timescale 1ns/1ps
`default_nettype none

`include "tcu_macros.svh"

module tcu_tb;
    import tcu_pkg::*;

    wire                            clk;
    wire                            reset;
    logic                           in_valid;
    tcu_fmt_e                       fmt;
    tcu_elem_t [`TCU_TERMS-2:0]     a_rows;
    tcu_elem_t [`TCU_TERMS-2:0]     b_cols;
    tcu_word_t                      c_val;
    wire                            busy;
    wire                            result_valid;
    wire tcu_word_t                 result;
    int                             compare_count;
    int                             error_count;
    int                             sent;
    int                             local_errors;
    int                             failed_tests;
    int                             test_count;
    int                             err_base;

    tb_clock clock0 (.clk(clk), .reset(reset));

    tcu_dot_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .fmt          (fmt),
        .a_rows       (a_rows),
        .b_cols       (b_cols),
        .c_val        (c_val),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    tcu_checker checker0 (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .fmt           (fmt),
        .a_rows        (a_rows),
        .b_cols        (b_cols),
        .c_val         (c_val),
        .busy          (busy),
        .result_valid  (result_valid),
        .result        (result),
        .compare_count (compare_count),
        .error_count   (error_count)
    );

    // Normal values only, exponents kept near the bias
    function automatic logic [15:0] rand_float_elem(input tcu_fmt_e f);
        logic [15:0] e;
        if ($urandom_range(9) == 0) return 16'h0000;
        e[15] = $urandom_range(1);
        if (f == FMT_FP16) begin
            e[14:10] = $urandom_range(17, 13);
            e[9:0] = $urandom();
        end else begin
            // Some tiny terms so they fall 32 or more below the maximum
            e[14:7] = ($urandom_range(5) == 0) ? $urandom_range(100, 95) : $urandom_range(130, 124);
            e[6:0] = $urandom();
        end
        return e;
    endfunction

    task automatic make_operands(input tcu_fmt_e f, output logic [3:0][15:0] a,
                                 output logic [3:0][15:0] b, output logic [31:0] c);
        for (int i = 0; i < 4; i++) begin
            a[i] = (f == FMT_INT8) ? 16'($urandom()) : rand_float_elem(f);
            b[i] = (f == FMT_INT8) ? 16'($urandom()) : rand_float_elem(f);
        end
        c = $urandom();
        if (f != FMT_INT8) begin
            c[30:23] = ($urandom_range(4) == 0) ? 8'd70 : 8'($urandom_range(130, 122));
        end
    endtask

    task automatic drive_request(input tcu_fmt_e f, input logic [3:0][15:0] a,
                                 input logic [3:0][15:0] b, input logic [31:0] c);
        in_valid <= 1'b1;
        fmt      <= f;
        a_rows   <= a;
        b_cols   <= b;
        c_val    <= c;
        sent = sent + 1;
    endtask

    task automatic wait_results(input int target, input int limit);
        int n;
        n = 0;
        while (compare_count < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (compare_count < target) begin
            $display("timeout while waiting for result %0d", target);
            local_errors++;
        end
    endtask

    task automatic send_and_wait(input tcu_fmt_e f, input logic [3:0][15:0] a,
                                 input logic [3:0][15:0] b, input logic [31:0] c);
        @(posedge clk);
        drive_request(f, a, b, c);
        @(posedge clk);
        in_valid <= 1'b0;
        wait_results(sent, 100);
    endtask

    task automatic run_random_singles(input tcu_fmt_e f, input int count);
        logic [3:0][15:0] a;
        logic [3:0][15:0] b;
        logic [31:0]      c;
        for (int i = 0; i < count; i++) begin
            make_operands(f, a, b, c);
            send_and_wait(f, a, b, c);
        end
    endtask

    task automatic run_burst(input int count);
        logic [3:0][15:0] a;
        logic [3:0][15:0] b;
        logic [31:0]      c;
        tcu_fmt_e         f;
        int               issued;
        int               n;
        bit               saw_busy;
        issued = 0;
        n = 0;
        saw_busy = 1'b0;
        while (issued < count && n < 2000) begin
            @(posedge clk);
            n++;
            if (busy) begin
                saw_busy = 1'b1;
            end
            // At most a full FIFO plus the set being accumulated
            if (!busy && (sent - compare_count) < (`TCU_FIFO_DEPTH + 1)) begin
                case ($urandom_range(2))
                    0: f = FMT_FP16;
                    1: f = FMT_BF16;
                    default: f = FMT_INT8;
                endcase
                make_operands(f, a, b, c);
                drive_request(f, a, b, c);
                issued++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        if (issued < count) begin
            $display("timeout while issuing the burst, %0d of %0d sent", issued, count);
            local_errors++;
        end
        if (!saw_busy) begin
            $display("busy never went high during the burst");
            local_errors++;
        end
        wait_results(sent, 500);
    endtask

    task automatic measure_latency();
        logic [3:0][15:0] a;
        logic [3:0][15:0] b;
        logic [31:0]      c;
        int               n;
        make_operands(FMT_FP16, a, b, c);
        @(posedge clk);
        drive_request(FMT_FP16, a, b, c);
        n = 0;
        while (n < 50) begin
            @(posedge clk);
            in_valid <= 1'b0;
            #1;
            n++;
            if (result_valid) break;
        end
        if (!result_valid) begin
            $display("timeout while waiting for the latency result");
            local_errors++;
        end else if (n != 9) begin
            $display("latency was %0d cycles, expected 9", n);
            local_errors++;
        end
        wait_results(sent, 20);
    endtask

    task automatic finish_test(input string name);
        int now;
        now = error_count + local_errors;
        test_count++;
        if (now == err_base) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail with %0d errors", name, now - err_base);
            failed_tests++;
        end
        err_base = now;
    endtask

    initial begin
        int n;
        in_valid = 1'b0;
        fmt = FMT_FP16;
        a_rows = '0;
        b_cols = '0;
        c_val = '0;
        sent = 0;
        local_errors = 0;
        failed_tests = 0;
        test_count = 0;
        err_base = 0;
        void'($urandom(32'hce6c89ca));

        n = 0;
        while (reset !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("reset never went low");
            local_errors++;
        end

        // Idle pipe stays quiet
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            if (result_valid !== 1'b0 || busy !== 1'b0) begin
                $display("result_valid or busy went high with no request");
                local_errors++;
            end
        end
        finish_test("reset");

        // Products that cancel, and a product cancelled by C
        send_and_wait(FMT_FP16, {16'h0000, 16'h0000, 16'hbc00, 16'h3c00},
                      {16'h0000, 16'h0000, 16'h4000, 16'h4000}, 32'h0000_0000);
        send_and_wait(FMT_FP16, {16'h0000, 16'h0000, 16'h0000, 16'h3c00},
                      {16'h0000, 16'h0000, 16'h0000, 16'h3c00}, 32'hbf80_0000);
        run_random_singles(FMT_FP16, 30);
        finish_test("fp16");

        // C lies 33 exponents below the product
        send_and_wait(FMT_BF16, {16'h0000, 16'h0000, 16'h0000, 16'h3f80},
                      {16'h0000, 16'h0000, 16'h0000, 16'h3f80}, 32'h2f80_0000);
        run_random_singles(FMT_BF16, 30);
        finish_test("bf16");

        run_random_singles(FMT_INT8, 30);
        finish_test("int8");

        run_burst(40);
        finish_test("burst");

        measure_latency();
        finish_test("latency");

        if (compare_count != sent) begin
            $display("only %0d of %0d results arrived", compare_count, sent);
            local_errors++;
        end
        $display("summary: %0d tests, %0d failed, %0d results compared, %0d errors",
                 test_count, failed_tests, compare_count, error_count + local_errors);
        if (error_count + local_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tcu_tb

`default_nettype wire

// File: tb.f
+incdir+common
common/tcu_pkg.sv
common/tcu_lane_if.sv
mul_exp/tcu_half_mul.sv
mul_exp/tcu_max_exp.sv
mul_exp/tcu_mul_exp.sv
source/tcu_term_fifo.sv
accumulate/tcu_align_acc.sv
source/tcu_dot_top.sv
tests/tb_clock.sv
tests/tcu_checker.sv
tests/tcu_tb.sv

// File: Bender.yml
package:
  name: tcu_dot_lane

sources:
  - include_dirs:
      - common
    files:
      - common/tcu_pkg.sv
      - common/tcu_lane_if.sv
      - mul_exp/tcu_half_mul.sv
      - mul_exp/tcu_max_exp.sv
      - mul_exp/tcu_mul_exp.sv
      - source/tcu_term_fifo.sv
      - accumulate/tcu_align_acc.sv
      - source/tcu_dot_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tests/tb_clock.sv
      - tests/tcu_checker.sv
      - tests/tcu_tb.sv
